/* project.f */
+incdir+include
logic/dma_pkg.sv
logic/dma_channel_regs.sv
logic/dma_xfer_seq.sv
logic/dma_burst_buffer.sv
logic/dma_ahb_driver.sv
logic/dma_master_top.sv
tests/ahb_mem_model.sv
tests/dma_master_assertions.sv
tests/dma_master_tb.sv

/* Makefile */
TOP = dma_master_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
		-f project.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* tests/dma_master_tb.sv */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_master_tb import dma_pkg::*; ();

    localparam word_t SEED    = 32'd91;
    localparam int    NROWS   = 6;
    localparam int    TIMEOUT = 4000;

    typedef struct packed {
        addr_t                src;
        addr_t                dst;
        logic [`DMA_TS_W-1:0] bytes;
        burst_sel_e           sel;
        logic                 mask;
        logic                 waits;
        hburst_e              last;
    } row_t;

    logic                 m_HCLK;
    logic                 m_HRESETn;
    logic                 start;
    addr_t                src_addr;
    addr_t                dest_addr;
    logic [`DMA_TS_W-1:0] xfer_bytes;
    burst_sel_e           burst_sel;
    logic                 intr_mask;
    logic                 intr_clear;
    logic                 busy;
    logic                 dma_intr;
    logic                 hbusreq;
    logic                 hgrant;
    htrans_e              htrans;
    hburst_e              hburst;
    logic [2:0]           hsize;
    addr_t                haddr;
    logic                 hwrite;
    word_t                hwdata;
    logic                 hready;
    word_t                hrdata;
    logic                 wait_en;
    word_t                wait_rng = SEED;
    logic                 load_en;
    addr_t                load_addr;
    word_t                load_data;
    logic                 log_clear;
    word_t                wr_beats;
    hburst_e              last_burst;
    logic                 non_single;

    row_t  rows [NROWS];
    word_t expected [32];
    word_t data_rng;

    dma_master_top u_dut (
        .m_HCLK     (m_HCLK),
        .m_HRESETn  (m_HRESETn),
        .start      (start),
        .src_addr   (src_addr),
        .dest_addr  (dest_addr),
        .xfer_bytes (xfer_bytes),
        .burst_sel  (burst_sel),
        .intr_mask  (intr_mask),
        .intr_clear (intr_clear),
        .busy       (busy),
        .dma_intr   (dma_intr),
        .hbusreq    (hbusreq),
        .hgrant     (hgrant),
        .htrans     (htrans),
        .hburst     (hburst),
        .hsize      (hsize),
        .haddr      (haddr),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hready     (hready),
        .hrdata     (hrdata)
    );

    ahb_mem_model u_mem (
        .m_HCLK     (m_HCLK),
        .m_HRESETn  (m_HRESETn),
        .wait_en    (wait_en),
        .rnd        (wait_rng),
        .hbusreq    (hbusreq),
        .hgrant     (hgrant),
        .htrans     (htrans),
        .hburst     (hburst),
        .haddr      (haddr),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hready     (hready),
        .hrdata     (hrdata),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .log_clear  (log_clear),
        .wr_beats   (wr_beats),
        .last_burst (last_burst),
        .non_single (non_single)
    );

    bind dma_master_top dma_master_assertions u_assert (
        .m_HCLK    (m_HCLK),
        .m_HRESETn (m_HRESETn),
        .htrans    (htrans),
        .haddr     (haddr),
        .hready    (hready),
        .hbusreq   (hbusreq),
        .intr_mask (intr_mask),
        .dma_intr  (dma_intr)
    );

    function automatic word_t next_rand(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_burst(input string name, input hburst_e got, input hburst_e exp);
        if (got !== exp)
            stop_on_error($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_trans(input string name, input htrans_e got, input htrans_e exp);
        if (got !== exp)
            stop_on_error($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < TIMEOUT) begin
            @(negedge m_HCLK);
            n++;
        end
        if (busy !== level)
            stop_on_error($sformatf("busy did not go to %0d within %0d cycles", level, TIMEOUT));
    endtask

    // fills the source block with fresh random words
    task automatic load_source(input addr_t base, input int n);
        int i;
        for (i = 0; i < n; i++) begin
            data_rng = next_rand(data_rng);
            expected[i] = data_rng;
            @(posedge m_HCLK);
            load_en   <= 1'b1;
            load_addr <= base + addr_t'(4 * i);
            load_data <= data_rng;
        end
        @(posedge m_HCLK);
        load_en   <= 1'b0;
        log_clear <= 1'b1;
        @(posedge m_HCLK);
        log_clear <= 1'b0;
    endtask

    task automatic run_row(input row_t r);
        int         nwords;
        int         i;
        logic [9:0] idx;
        nwords = int'(r.bytes >> 2);
        load_source(r.src, nwords);
        @(posedge m_HCLK);
        src_addr   <= r.src;
        dest_addr  <= r.dst;
        xfer_bytes <= r.bytes;
        burst_sel  <= r.sel;
        intr_mask  <= r.mask;
        wait_en    <= r.waits;
        start      <= 1'b1;
        @(posedge m_HCLK);
        start <= 1'b0;
        @(negedge m_HCLK);
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_flag("dma_intr", dma_intr, !r.mask);  // status set as busy falls
        for (i = 0; i < nwords; i++) begin
            idx = r.dst[11:2] + 10'(i);
            check_word($sformatf("mem[0x%03h]", {idx, 2'b00}), u_mem.mem[idx], expected[i]);
        end
        check_word("wr_beats", wr_beats, word_t'(nwords));
        check_burst("last_burst", last_burst, r.last);
        check_flag("non_single", non_single, r.sel != BSEL_SINGLE);
        @(posedge m_HCLK);
        intr_clear <= 1'b1;
        @(posedge m_HCLK);
        intr_clear <= 1'b0;
        @(negedge m_HCLK);
        check_flag("dma_intr", dma_intr, 1'b0);
    endtask

    initial begin
        m_HCLK = 1'b0;
        forever #4 m_HCLK = ~m_HCLK;
    end

    always @(posedge m_HCLK) begin
        wait_rng <= next_rand(wait_rng);
    end

    always @(posedge m_HCLK) begin
        if (u_dut.u_assert.any_failed)
            stop_on_error("a bus protocol assertion failed");
    end

    initial begin
        int k;
        // src, dest, bytes, burst_sel, mask, waits, last burst code
        rows[0] = '{32'h000, 32'h400, 12'd128, BSEL_INCR4, 1'b0, 1'b0, INCR4};
        rows[1] = '{32'h100, 32'h600, 12'd52, BSEL_INCR8, 1'b0, 1'b0, INCR};  // 8 + 5 tail
        rows[2] = '{32'h200, 32'h800, 12'd20, BSEL_SINGLE, 1'b0, 1'b0, SINGLE};
        rows[3] = '{32'h300, 32'hA00, 12'd100, BSEL_INCR16, 1'b0, 1'b1, INCR};
        rows[4] = '{32'h080, 32'hC00, 12'd24, BSEL_INCR4, 1'b1, 1'b1, INCR};
        rows[5] = '{32'h140, 32'hE00, 12'd64, burst_sel_e'(3'd5), 1'b0, 1'b1, INCR16};

        data_rng   = SEED;
        m_HRESETn  = 1'b0;
        start      = 1'b0;
        src_addr   = '0;
        dest_addr  = '0;
        xfer_bytes = '0;
        burst_sel  = BSEL_SINGLE;
        intr_mask  = 1'b0;
        intr_clear = 1'b0;
        wait_en    = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        log_clear  = 1'b0;

        repeat (8) @(posedge m_HCLK);
        m_HRESETn <= 1'b1;
        @(negedge m_HCLK);
        check_flag("hbusreq", hbusreq, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("dma_intr", dma_intr, 1'b0);
        check_flag("hwrite", hwrite, 1'b0);
        check_trans("htrans", htrans, IDLE);
        check_word("hsize", word_t'(hsize), word_t'(3'b010));  // AHB word size

        for (k = 0; k < NROWS; k++)
            run_row(rows[k]);

        repeat (4) @(posedge m_HCLK);
        if (!u_dut.u_assert.any_failed) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_on_error("a bus protocol assertion failed");
        end
    end

endmodule

/* tests/dma_master_assertions.sv */
`timescale 1ns/10ps

module dma_master_assertions import dma_pkg::*; (
    input logic    m_HCLK,
    input logic    m_HRESETn,
    input htrans_e htrans,
    input addr_t   haddr,
    input logic    hready,
    input logic    hbusreq,
    input logic    intr_mask,
    input logic    dma_intr
);

    logic seq_bad  = 1'b0;
    logic addr_bad = 1'b0;
    logic req_bad  = 1'b0;
    logic intr_bad = 1'b0;
    logic any_failed;

    assign any_failed = seq_bad | addr_bad | req_bad | intr_bad;

    // SEQ only continues a burst
    seq_follows_active: assert property (@(posedge m_HCLK) disable iff (!m_HRESETn)
        (htrans == SEQ) |-> ($past(htrans) == NONSEQ || $past(htrans) == SEQ))
    else begin
        seq_bad = 1'b1;
        $error("htrans is SEQ without a preceding NONSEQ or SEQ");
    end

    addr_held_on_wait: assert property (@(posedge m_HCLK) disable iff (!m_HRESETn)
        !hready |=> $stable(haddr))
    else begin
        addr_bad = 1'b1;
        $error("haddr changed while hready was low");
    end

    no_request_after_reset: assert property (@(posedge m_HCLK)
        $rose(m_HRESETn) |-> !hbusreq)
    else begin
        req_bad = 1'b1;
        $error("hbusreq is high right after reset");
    end

    intr_masked: assert property (@(posedge m_HCLK) disable iff (!m_HRESETn)
        intr_mask |-> !dma_intr)
    else begin
        intr_bad = 1'b1;
        $error("dma_intr is high while intr_mask is set");
    end

endmodule

/* tests/ahb_mem_model.sv */
`timescale 1ns/10ps

module ahb_mem_model import dma_pkg::*; (
    input  logic    m_HCLK,
    input  logic    m_HRESETn,
    input  logic    wait_en,
    input  word_t   rnd,
    input  logic    hbusreq,
    output logic    hgrant,
    input  htrans_e htrans,
    input  hburst_e hburst,
    input  addr_t   haddr,
    input  logic    hwrite,
    input  word_t   hwdata,
    output logic    hready,
    output word_t   hrdata,
    input  logic    load_en,
    input  addr_t   load_addr,
    input  word_t   load_data,
    input  logic    log_clear,
    output word_t   wr_beats,
    output hburst_e last_burst,
    output logic    non_single
);

    word_t      mem [1024];  // 4 KB of word storage
    logic       dph_valid;
    logic       dph_write;
    logic [9:0] dph_idx;
    logic [3:0] gnt_cnt;
    logic       accept;

    assign accept = hgrant && hready && (htrans == NONSEQ || htrans == SEQ);
    assign hready = !wait_en || (rnd[2:0] > 3'd2);  // stalls about 3 cycles in 8
    assign hrdata = (dph_valid && !dph_write) ? mem[dph_idx] : '0;

    // grant follows the request, later when waits are on
    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            hgrant  <= 1'b0;
            gnt_cnt <= '0;
        end else if (!hbusreq) begin
            hgrant  <= 1'b0;
            gnt_cnt <= '0;
        end else if (!hgrant) begin
            gnt_cnt <= gnt_cnt + 4'd1;
            if (gnt_cnt >= (wait_en ? 4'd5 : 4'd0))
                hgrant <= 1'b1;
        end
    end

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            dph_valid  <= 1'b0;
            dph_write  <= 1'b0;
            dph_idx    <= '0;
            wr_beats   <= '0;
            last_burst <= SINGLE;
            non_single <= 1'b0;
        end else if (log_clear) begin
            wr_beats   <= '0;
            non_single <= 1'b0;
        end else if (hready) begin
            dph_valid <= accept;
            dph_write <= hwrite;
            dph_idx   <= haddr[11:2];
            if (accept && hburst != SINGLE)
                non_single <= 1'b1;
            if (accept && hwrite)
                last_burst <= hburst;  // burst code of the latest write beat
            if (dph_valid && dph_write)
                wr_beats <= wr_beats + 32'd1;
        end
    end

    always_ff @(posedge m_HCLK) begin
        if (load_en)
            mem[load_addr[11:2]] <= load_data;  // backdoor preload
        else if (hready && dph_valid && dph_write)
            mem[dph_idx] <= hwdata;
    end

endmodule

/* logic/dma_master_top.sv */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_master_top import dma_pkg::*; (
    input  logic                 m_HCLK,
    input  logic                 m_HRESETn,
    input  logic                 start,
    input  addr_t                src_addr,
    input  addr_t                dest_addr,
    input  logic [`DMA_TS_W-1:0] xfer_bytes,
    input  burst_sel_e           burst_sel,
    input  logic                 intr_mask,
    input  logic                 intr_clear,
    output logic                 busy,
    output logic                 dma_intr,
    output logic                 hbusreq,
    input  logic                 hgrant,
    output htrans_e              htrans,
    output hburst_e              hburst,
    output logic [2:0]           hsize,
    output addr_t                haddr,
    output logic                 hwrite,
    output word_t                hwdata,
    input  logic                 hready,
    input  word_t                hrdata
);

    addr_t   src_addr_q;
    addr_t   dest_addr_q;
    words_t  words_left;
    beat_t   burst_len;
    hburst_e burst_code;
    logic    src_adv;
    logic    dest_adv;
    logic    done;
    logic    cmd_active;
    logic    cmd_write;
    logic    cmd_first;
    logic    fill_clear;
    logic    drain_clear;
    logic    cap_en;
    word_t   cap_data;
    logic    buf_adv;
    word_t   buf_data;

    dma_channel_regs u_regs (
        .m_HCLK      (m_HCLK),
        .m_HRESETn   (m_HRESETn),
        .start       (start),
        .src_addr    (src_addr),
        .dest_addr   (dest_addr),
        .xfer_bytes  (xfer_bytes),
        .burst_sel   (burst_sel),
        .intr_mask   (intr_mask),
        .intr_clear  (intr_clear),
        .src_adv     (src_adv),
        .dest_adv    (dest_adv),
        .done        (done),
        .src_addr_q  (src_addr_q),
        .dest_addr_q (dest_addr_q),
        .words_left  (words_left),
        .burst_len   (burst_len),
        .burst_code  (burst_code),
        .busy        (busy),
        .dma_intr    (dma_intr)
    );

    dma_xfer_seq u_seq (
        .m_HCLK      (m_HCLK),
        .m_HRESETn   (m_HRESETn),
        .start       (start),
        .hgrant      (hgrant),
        .hready      (hready),
        .burst_len   (burst_len),
        .words_left  (words_left),
        .hbusreq     (hbusreq),
        .cmd_active  (cmd_active),
        .cmd_write   (cmd_write),
        .cmd_first   (cmd_first),
        .src_adv     (src_adv),
        .dest_adv    (dest_adv),
        .done        (done),
        .fill_clear  (fill_clear),
        .drain_clear (drain_clear)
    );

    dma_burst_buffer u_buf (
        .m_HCLK      (m_HCLK),
        .fill_clear  (fill_clear),
        .drain_clear (drain_clear),
        .wr_en       (cap_en),
        .wr_data     (cap_data),
        .rd_adv      (buf_adv),
        .rd_data     (buf_data)
    );

    dma_ahb_driver u_drv (
        .m_HCLK      (m_HCLK),
        .m_HRESETn   (m_HRESETn),
        .hready      (hready),
        .hrdata      (hrdata),
        .cmd_active  (cmd_active),
        .cmd_write   (cmd_write),
        .cmd_first   (cmd_first),
        .burst_code  (burst_code),
        .src_addr_q  (src_addr_q),
        .dest_addr_q (dest_addr_q),
        .buf_data    (buf_data),
        .htrans      (htrans),
        .hburst      (hburst),
        .hsize       (hsize),
        .haddr       (haddr),
        .hwrite      (hwrite),
        .hwdata      (hwdata),
        .cap_en      (cap_en),
        .cap_data    (cap_data),
        .buf_adv     (buf_adv)
    );

endmodule

/* logic/dma_ahb_driver.sv */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_ahb_driver import dma_pkg::*; (
    input  logic       m_HCLK,
    input  logic       m_HRESETn,
    input  logic       hready,
    input  word_t      hrdata,
    input  logic       cmd_active,
    input  logic       cmd_write,
    input  logic       cmd_first,
    input  hburst_e    burst_code,
    input  addr_t      src_addr_q,
    input  addr_t      dest_addr_q,
    input  word_t      buf_data,
    output htrans_e    htrans,
    output hburst_e    hburst,
    output logic [2:0] hsize,
    output addr_t      haddr,
    output logic       hwrite,
    output word_t      hwdata,
    output logic       cap_en,
    output word_t      cap_data,
    output logic       buf_adv
);

    logic addr_valid;
    logic dph_valid;  // a beat is in its data phase
    logic dph_write;

    assign addr_valid = (htrans == NONSEQ) || (htrans == SEQ);
    assign hsize      = `DMA_HSIZE_WORD;

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            htrans    <= IDLE;
            hburst    <= SINGLE;
            haddr     <= '0;
            hwrite    <= 1'b0;
            dph_valid <= 1'b0;
            dph_write <= 1'b0;
        end else if (hready) begin
            dph_valid <= addr_valid;
            dph_write <= hwrite;
            hwrite    <= cmd_active && cmd_write;
            if (cmd_active) begin
                haddr <= cmd_write ? dest_addr_q : src_addr_q;
                if (cmd_first) begin
                    htrans <= NONSEQ;
                    hburst <= burst_code;
                end else if (htrans == IDLE) begin
                    htrans <= NONSEQ;  // resumed after lost grant
                    hburst <= INCR;
                end else begin
                    htrans <= SEQ;
                end
            end else begin
                htrans <= IDLE;
            end
        end
    end

    // write beat accepted, its data goes out next cycle
    assign buf_adv = hready && addr_valid && hwrite;

    always_ff @(posedge m_HCLK) begin
        if (buf_adv)
            hwdata <= buf_data;
    end

    assign cap_en   = hready && dph_valid && !dph_write;
    assign cap_data = hrdata;

endmodule

/* logic/dma_burst_buffer.sv */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_burst_buffer import dma_pkg::*; (
    input  logic  m_HCLK,
    input  logic  fill_clear,
    input  logic  drain_clear,
    input  logic  wr_en,
    input  word_t wr_data,
    input  logic  rd_adv,
    output word_t rd_data
);

    word_t                    mem [`DMA_BUF_DEPTH];
    logic [`DMA_BUF_IDX_W-1:0] wr_idx;
    logic [`DMA_BUF_IDX_W-1:0] rd_idx;

    always_ff @(posedge m_HCLK) begin
        if (fill_clear)
            wr_idx <= '0;
        else if (wr_en)
            wr_idx <= wr_idx + 1'b1;
    end

    always_ff @(posedge m_HCLK) begin
        if (drain_clear)
            rd_idx <= '0;
        else if (rd_adv)
            rd_idx <= rd_idx + 1'b1;
    end

    always_ff @(posedge m_HCLK) begin
        if (wr_en)
            mem[wr_idx] <= wr_data;
    end

    assign rd_data = mem[rd_idx];  // word for the next write beat

endmodule

/* logic/dma_xfer_seq.sv */
`timescale 1ns/10ps

module dma_xfer_seq import dma_pkg::*; (
    input  logic   m_HCLK,
    input  logic   m_HRESETn,
    input  logic   start,
    input  logic   hgrant,
    input  logic   hready,
    input  beat_t  burst_len,
    input  words_t words_left,
    output logic   hbusreq,
    output logic   cmd_active,
    output logic   cmd_write,
    output logic   cmd_first,
    output logic   src_adv,
    output logic   dest_adv,
    output logic   done,
    output logic   fill_clear,
    output logic   drain_clear
);

    seq_state_e state;
    seq_state_e state_nx;
    beat_t      acnt;      // address beats issued
    beat_t      dcnt;      // data beats completed
    beat_t      len_q;     // length of the burst in flight
    logic       a_pend;
    logic       a_wr;
    logic       d_pend;
    logic       d_wr;
    logic       issue;
    logic       rd_done;
    logic       wr_done;
    logic       go_read;
    logic       go_write;

    assign cmd_active = (state == SEQ_READ || state == SEQ_WRITE) && (acnt < len_q) && hgrant;
    assign cmd_write  = (state == SEQ_WRITE);
    assign cmd_first  = (acnt == '0);
    assign issue      = cmd_active && hready;
    assign src_adv    = issue && !cmd_write;
    assign dest_adv   = issue && cmd_write;

    assign rd_done = hready && d_pend && !d_wr;
    assign wr_done = hready && d_pend && d_wr;

    assign hbusreq     = (state != SEQ_IDLE) && (state != SEQ_DONE);
    assign done        = (state == SEQ_DONE);
    assign fill_clear  = go_read;
    assign drain_clear = go_write;

    always_comb begin
        state_nx = state;
        go_read  = 1'b0;
        go_write = 1'b0;
        case (state)
            SEQ_IDLE: begin
                if (start)
                    state_nx = SEQ_REQ;
            end
            SEQ_REQ: begin
                if (hgrant) begin
                    state_nx = SEQ_READ;
                    go_read  = 1'b1;
                end
            end
            SEQ_READ: begin
                // all read data must be in the buffer before writing
                if (acnt == len_q && dcnt == len_q) begin
                    state_nx = SEQ_WRITE;
                    go_write = 1'b1;
                end
            end
            SEQ_WRITE: begin
                if (acnt == len_q) begin
                    if (words_left != '0) begin
                        state_nx = SEQ_READ;  // overlaps last write data phase
                        go_read  = 1'b1;
                    end else if (dcnt == len_q) begin
                        state_nx = SEQ_DONE;
                    end
                end
            end
            SEQ_DONE: state_nx = SEQ_IDLE;
            default:  state_nx = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            state  <= SEQ_IDLE;
            acnt   <= '0;
            dcnt   <= '0;
            len_q  <= '0;
            a_pend <= 1'b0;
            a_wr   <= 1'b0;
            d_pend <= 1'b0;
            d_wr   <= 1'b0;
        end else begin
            state <= state_nx;
            if (go_read)
                len_q <= burst_len;
            if (go_read || go_write) begin
                acnt <= '0;
                dcnt <= '0;
            end else begin
                if (issue)
                    acnt <= acnt + 1'b1;
                if ((state == SEQ_READ && rd_done) || (state == SEQ_WRITE && wr_done))
                    dcnt <= dcnt + 1'b1;
            end
            // address then data phase, both advance only on hready
            if (hready) begin
                a_pend <= cmd_active;
                a_wr   <= cmd_write;
                d_pend <= a_pend;
                d_wr   <= a_wr;
            end
        end
    end

endmodule

/* logic/dma_channel_regs.sv */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_channel_regs import dma_pkg::*; (
    input  logic                m_HCLK,
    input  logic                m_HRESETn,
    input  logic                start,
    input  addr_t               src_addr,
    input  addr_t               dest_addr,
    input  logic [`DMA_TS_W-1:0] xfer_bytes,
    input  burst_sel_e          burst_sel,
    input  logic                intr_mask,
    input  logic                intr_clear,
    input  logic                src_adv,
    input  logic                dest_adv,
    input  logic                done,
    output addr_t               src_addr_q,
    output addr_t               dest_addr_q,
    output words_t              words_left,
    output beat_t               burst_len,
    output hburst_e             burst_code,
    output logic                busy,
    output logic                dma_intr
);

    burst_sel_e sel_q;
    beat_t      sel_len;
    hburst_e    sel_code;
    logic       status;
    logic       load;

    assign load = start && !busy;  // a start while running is ignored

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            busy       <= 1'b0;
            status     <= 1'b0;
            words_left <= '0;
            sel_q      <= BSEL_SINGLE;
        end else begin
            if (load) begin
                busy       <= 1'b1;
                words_left <= xfer_bytes[`DMA_TS_W-1:2];
                sel_q      <= burst_sel;
            end else begin
                if (done)
                    busy <= 1'b0;
                if (dest_adv)
                    words_left <= words_left - 1'b1;  // one word per write beat
            end
            if (done)
                status <= 1'b1;
            else if (intr_clear)
                status <= 1'b0;
        end
    end

    always_ff @(posedge m_HCLK) begin
        if (load) begin
            src_addr_q  <= src_addr;
            dest_addr_q <= dest_addr;
        end else begin
            if (src_adv)
                src_addr_q <= src_addr_q + 32'd4;
            if (dest_adv)
                dest_addr_q <= dest_addr_q + 32'd4;
        end
    end

    // burst length for the next burst, tail shortened to INCR
    always_comb begin
        case (sel_q)
            BSEL_SINGLE: begin
                sel_len  = 5'd1;
                sel_code = SINGLE;
            end
            BSEL_INCR4: begin
                sel_len  = 5'd4;
                sel_code = INCR4;
            end
            BSEL_INCR8: begin
                sel_len  = 5'd8;
                sel_code = INCR8;
            end
            default: begin
                sel_len  = 5'd16;
                sel_code = INCR16;
            end
        endcase
        burst_len  = sel_len;
        burst_code = sel_code;
        if (sel_code != SINGLE && words_left < words_t'(sel_len)) begin
            burst_len  = beat_t'(words_left);
            burst_code = INCR;
        end
    end

    assign dma_intr = status && !intr_mask;

endmodule

/* logic/dma_pkg.sv */
`include "dma_defines.svh"

package dma_pkg;

    typedef logic [`DMA_DATA_W-1:0] word_t;
    typedef logic [`DMA_ADDR_W-1:0] addr_t;
    typedef logic [`DMA_BEAT_W-1:0] beat_t;
    typedef logic [`DMA_TS_W-3:0]   words_t;  // byte count over four

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        INCR4  = 3'b011,
        INCR8  = 3'b101,
        INCR16 = 3'b111
    } hburst_e;

    // channel burst-select field, codes above 2 all mean INCR16
    typedef enum logic [2:0] {
        BSEL_SINGLE = 3'd0,
        BSEL_INCR4  = 3'd1,
        BSEL_INCR8  = 3'd2,
        BSEL_INCR16 = 3'd3
    } burst_sel_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_REQ,
        SEQ_READ,
        SEQ_WRITE,
        SEQ_DONE
    } seq_state_e;

endpackage

/* include/dma_defines.svh */
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// AHB bus widths
`define DMA_DATA_W      32
`define DMA_ADDR_W      32

// transfer size in bytes, always a word multiple
`define DMA_TS_W        12

// local burst buffer, one INCR16 worth of words
`define DMA_BUF_DEPTH   16
`define DMA_BUF_IDX_W   4

// beat counter holds 0..16
`define DMA_BEAT_W      5

// HSIZE code for 32-bit transfers
`define DMA_HSIZE_WORD  3'b010

`endif
